// ==== build.f ====
logic/trail_pkg.sv
logic/trail_store.sv
logic/var_lookup.sv
logic/level_index.sv
logic/trail_control.sv
logic/trail_manager.sv
testbench/tb_trail_manager.sv

// ==== logic/level_index.sv ====
/*
 * Decision level start table
 *   Trail index where each level begins, written on every push
 *   Level 1 start held in a reset register, level 0 always starts at 0
 *   Truncate height lookup, clamped to the current height
 */
module level_index (
    input  logic              clk,
    input  logic              reset,
    input  logic              push_accept,
    input  trail_pkg::level_t push_level,
    input  trail_pkg::index_t height,
    input  logic              clear_all,
    input  trail_pkg::level_t truncate_target,
    output trail_pkg::index_t truncate_height
);

    import trail_pkg::*;

    // Extra bit so target+1 never wraps
    logic [LEVEL_W:0] push_next;
    logic [LEVEL_W:0] trunc_next;

    index_t level1_start;
    index_t start_table [2:MAX_VARS];
    index_t start_lookup;

    assign push_next  = {1'b0, push_level} + 1'b1;
    assign trunc_next = {1'b0, truncate_target} + 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level1_start <= '0;
        end else if (clear_all) begin
            level1_start <= '0;
        end else if (push_accept && (push_next == 1)) begin
            level1_start <= height + 1'b1;
        end
    end

    // Each push moves the end of its own level, i.e. the start of the next
    always_ff @(posedge clk) begin
        if (push_accept && (push_next >= 2) && (push_next <= MAX_VARS)) begin
            start_table[push_next[VAR_ADDR_W-1:0]] <= height + 1'b1;
        end
    end

    always_comb begin
        if (trunc_next == 1) begin
            start_lookup = level1_start;
        end else if (trunc_next <= MAX_VARS) begin
            start_lookup = start_table[trunc_next[VAR_ADDR_W-1:0]];
        end else begin
            // Target above any level, keep everything
            start_lookup = height;
        end
    end

    // Stale starts from a deeper past never grow the trail
    assign truncate_height = (start_lookup > height) ? height : start_lookup;

endmodule

// ==== logic/trail_control.sv ====
/*
 * Trail control
 *   Height and current decision level registers
 *   Push acceptance and clear / truncate / backtrack priority
 *   Iterative backtrack FSM, one retired entry per cycle, newest first
 */
module trail_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  logic                    push_is_decision,
    input  trail_pkg::level_t       push_level,
    input  logic                    clear_all,
    input  logic                    truncate_en,
    input  trail_pkg::level_t       truncate_target,
    input  trail_pkg::index_t       truncate_height,
    input  logic                    backtrack_en,
    input  trail_pkg::level_t       backtrack_target,
    input  trail_pkg::trail_entry_t peek_entry,
    output logic                    push_accept,
    output trail_pkg::index_t       height,
    output trail_pkg::level_t       current_level,
    output trail_pkg::index_t       peek_index,
    output logic                    retire,
    output trail_pkg::bt_item_t     backtrack_item,
    output logic                    backtrack_done
);

    import trail_pkg::*;

    bt_state_t state;
    bt_state_t state_d;
    index_t    height_d;
    level_t    level_d;
    // One past the next entry to inspect
    index_t    bt_index;
    index_t    bt_index_d;
    level_t    bt_target;
    level_t    bt_target_d;

    logic bt_has_entry;
    logic fsm_active;

    assign push_accept = push && (height < MAX_VARS);

    // Clear and truncate preempt the backtrack FSM
    assign fsm_active = !clear_all && !truncate_en;

    assign peek_index   = (bt_index != '0) ? bt_index - 1'b1 : '0;
    assign bt_has_entry = (bt_index != '0) && (peek_entry.level > bt_target);

    assign retire         = fsm_active && (state == LOOP) && bt_has_entry;
    assign backtrack_done = fsm_active && (state == COMPLETE);

    // Removed assignment, zero between items
    always_comb begin
        backtrack_item = '0;
        if (retire) begin
            backtrack_item.variable    = peek_entry.variable;
            backtrack_item.value       = peek_entry.value;
            backtrack_item.is_decision = peek_entry.is_decision;
        end
    end

    always_comb begin
        height_d    = height;
        level_d     = current_level;
        state_d     = state;
        bt_index_d  = bt_index;
        bt_target_d = bt_target;

        // Push goes first, anything below may overwrite the height
        if (push_accept) begin
            height_d = height + 1'b1;
            if (push_is_decision) begin
                level_d = push_level;
            end
        end

        if (clear_all) begin
            height_d = '0;
            level_d  = '0;
            state_d  = IDLE;
        end else if (truncate_en) begin
            height_d = truncate_height;
            level_d  = truncate_target;
            state_d  = IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (backtrack_en) begin
                        bt_target_d = backtrack_target;
                        bt_index_d  = height;
                        state_d     = LOOP;
                    end
                end
                LOOP: begin
                    // Step down while entries sit above the target level
                    if (bt_has_entry) begin
                        bt_index_d = peek_index;
                    end else begin
                        state_d = COMPLETE;
                    end
                end
                COMPLETE: begin
                    height_d = bt_index;
                    level_d  = bt_target;
                    state_d  = IDLE;
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            height        <= '0;
            current_level <= '0;
            state         <= IDLE;
            bt_index      <= '0;
            bt_target     <= '0;
        end else begin
            height        <= height_d;
            current_level <= level_d;
            state         <= state_d;
            bt_index      <= bt_index_d;
            bt_target     <= bt_target_d;
        end
    end

endmodule

// ==== logic/trail_manager.sv ====
/*
 * Assignment trail top level
 *   Trail memory, variable lookup tables, level start table, control
 *   Push, query, indexed read, iterative backtrack, truncate, clear-all
 */
module trail_manager (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  trail_pkg::push_req_t      push_req,
    input  trail_pkg::var_t           query_var,
    input  trail_pkg::index_t         read_index,
    input  logic                     backtrack_en,
    input  trail_pkg::level_t         backtrack_target,
    input  logic                     truncate_en,
    input  trail_pkg::level_t         truncate_target,
    input  logic                     clear_all,
    output trail_pkg::index_t         height,
    output trail_pkg::level_t         current_level,
    output trail_pkg::query_result_t  query,
    output trail_pkg::trail_entry_t   read_entry,
    output logic                     backtrack_valid,
    output trail_pkg::bt_item_t       backtrack_item,
    output logic                     backtrack_done
);

    import trail_pkg::*;

    logic         push_accept;
    trail_entry_t push_entry;
    index_t       bt_peek_index;
    trail_entry_t bt_peek_entry;
    index_t       lookup_index;
    trail_entry_t lookup_entry;
    index_t       truncate_height;

    // Push request stored as-is
    assign push_entry.variable    = push_req.variable;
    assign push_entry.value       = push_req.value;
    assign push_entry.level       = push_req.level;
    assign push_entry.is_decision = push_req.is_decision;
    assign push_entry.reason      = push_req.reason;

    trail_store u_store (
        .clk          (clk),
        .write_en     (push_accept),
        .write_index  (height),
        .write_entry  (push_entry),
        .height       (height),
        .read_index   (read_index),
        .peek_index   (bt_peek_index),
        .lookup_index (lookup_index),
        .read_entry   (read_entry),
        .peek_entry   (bt_peek_entry),
        .lookup_entry (lookup_entry)
    );

    var_lookup u_lookup (
        .clk           (clk),
        .push_accept   (push_accept),
        .push_req      (push_req),
        .height        (height),
        .retire        (backtrack_valid),
        .retire_var    (backtrack_item.variable),
        .query_var     (query_var),
        .current_level (current_level),
        .lookup_entry  (lookup_entry),
        .lookup_index  (lookup_index),
        .query         (query)
    );

    level_index u_levels (
        .clk             (clk),
        .reset           (reset),
        .push_accept     (push_accept),
        .push_level      (push_req.level),
        .height          (height),
        .clear_all       (clear_all),
        .truncate_target (truncate_target),
        .truncate_height (truncate_height)
    );

    // Retire strobe doubles as backtrack_valid
    trail_control u_control (
        .clk              (clk),
        .reset            (reset),
        .push             (push),
        .push_is_decision (push_req.is_decision),
        .push_level       (push_req.level),
        .clear_all        (clear_all),
        .truncate_en      (truncate_en),
        .truncate_target  (truncate_target),
        .truncate_height  (truncate_height),
        .backtrack_en     (backtrack_en),
        .backtrack_target (backtrack_target),
        .peek_entry       (bt_peek_entry),
        .push_accept      (push_accept),
        .height           (height),
        .current_level    (current_level),
        .peek_index       (bt_peek_index),
        .retire           (backtrack_valid),
        .backtrack_item   (backtrack_item),
        .backtrack_done   (backtrack_done)
    );

endmodule

// ==== logic/trail_pkg.sv ====
/*
 * Shared definitions for the SAT solver assignment trail
 *   Trail capacity, field widths and table address widths
 *   Sentinels for retired variables and out-of-trail reads
 *   Trail entry, push request, backtrack item and query result structs
 *   Backtrack state encoding
 */
package trail_pkg;

    // Trail depth, also the highest legal variable ID
    localparam int MAX_VARS = 256;

    // Field widths
    localparam int VAR_W    = 32;
    localparam int LEVEL_W  = 16;
    localparam int INDEX_W  = 16;
    localparam int REASON_W = 16;

    // Address of a trail slot
    localparam int TRAIL_ADDR_W = $clog2(MAX_VARS);
    // Address into tables with MAX_VARS+1 slots (variable IDs, level starts)
    localparam int VAR_ADDR_W = $clog2(MAX_VARS + 1);

    typedef logic [VAR_W-1:0]    var_t;
    typedef logic [LEVEL_W-1:0]  level_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [REASON_W-1:0] reason_t;

    // Index of a variable removed by backtrack, never below height
    localparam index_t STALE_INDEX = '1;
    // Reason returned for reads past the top of the trail
    localparam reason_t NO_REASON = '1;

    // One trail slot, 66 bits
    typedef struct packed {
        var_t    variable;
        logic    value;
        level_t  level;
        logic    is_decision;
        reason_t reason;
    } trail_entry_t;

    // Fields that come with a push strobe
    typedef struct packed {
        var_t    variable;
        logic    value;
        level_t  level;
        logic    is_decision;
        reason_t reason;
    } push_req_t;

    // Assignment streamed out during backtrack
    typedef struct packed {
        var_t variable;
        logic value;
        logic is_decision;
    } bt_item_t;

    typedef struct packed {
        logic   valid;
        level_t level;
        logic   value;
    } query_result_t;

    typedef enum logic [1:0] {IDLE, LOOP, COMPLETE} bt_state_t;

endpackage

// ==== logic/trail_store.sv ====
/*
 * Trail entry memory
 *   MAX_VARS slots, one synchronous write port
 *   Asynchronous reads for the external port, backtrack peek and query check
 *   External read masked above the trail height
 */
module trail_store (
    input  logic                   clk,
    input  logic                   write_en,
    input  trail_pkg::index_t       write_index,
    input  trail_pkg::trail_entry_t write_entry,
    input  trail_pkg::index_t       height,
    input  trail_pkg::index_t       read_index,
    input  trail_pkg::index_t       peek_index,
    input  trail_pkg::index_t       lookup_index,
    output trail_pkg::trail_entry_t read_entry,
    output trail_pkg::trail_entry_t peek_entry,
    output trail_pkg::trail_entry_t lookup_entry
);

    import trail_pkg::*;

    // Storage, no reset so it maps onto distributed RAM
    trail_entry_t mem [0:MAX_VARS-1];

    always_ff @(posedge clk) begin
        // Control guarantees write_index < MAX_VARS
        if (write_en) begin
            mem[write_index[TRAIL_ADDR_W-1:0]] <= write_entry;
        end
    end

    // External read, only live entries are visible
    always_comb begin
        if (read_index < height) begin
            read_entry = mem[read_index[TRAIL_ADDR_W-1:0]];
        end else begin
            // Empty slot past the top of the trail
            read_entry        = '0;
            read_entry.reason = NO_REASON;
        end
    end

    // Entry just below the backtrack pointer
    assign peek_entry = mem[peek_index[TRAIL_ADDR_W-1:0]];

    // Cross-check port, caller validates the index against height
    assign lookup_entry = mem[lookup_index[TRAIL_ADDR_W-1:0]];

endmodule

// ==== logic/var_lookup.sv ====
/*
 * Per-variable assignment tables
 *   Level, value and trail index of every variable ID
 *   Updated on push, marked stale on backtrack retire
 *   Combinational query with stale-entry rejection against the trail
 */
module var_lookup (
    input  logic                     clk,
    input  logic                     push_accept,
    input  trail_pkg::push_req_t      push_req,
    input  trail_pkg::index_t         height,
    input  logic                     retire,
    input  trail_pkg::var_t           retire_var,
    input  trail_pkg::var_t           query_var,
    input  trail_pkg::level_t         current_level,
    input  trail_pkg::trail_entry_t   lookup_entry,
    output trail_pkg::index_t         lookup_index,
    output trail_pkg::query_result_t  query
);

    import trail_pkg::*;

    // Tables indexed by 1-based variable ID
    level_t var_level [1:MAX_VARS];
    logic   var_value [1:MAX_VARS];
    index_t var_index [1:MAX_VARS];

    logic                  push_ok;
    logic                  retire_ok;
    logic                  query_ok;
    logic [VAR_ADDR_W-1:0] push_addr;
    logic [VAR_ADDR_W-1:0] retire_addr;
    logic [VAR_ADDR_W-1:0] query_addr;

    // Recorded assignment of the queried variable
    level_t rec_level;
    logic   rec_value;

    function automatic logic var_in_range(input var_t v);
        return (v != '0) && (v <= MAX_VARS);
    endfunction

    assign push_ok     = var_in_range(push_req.variable);
    assign retire_ok   = var_in_range(retire_var);
    assign query_ok    = var_in_range(query_var);
    assign push_addr   = push_req.variable[VAR_ADDR_W-1:0];
    assign retire_addr = retire_var[VAR_ADDR_W-1:0];
    assign query_addr  = query_var[VAR_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        // Removed variable can never pass the height check again
        if (retire && retire_ok) begin
            var_level[retire_addr] <= '0;
            var_value[retire_addr] <= 1'b0;
            var_index[retire_addr] <= STALE_INDEX;
        end
        // New entry lands at the current top of the trail
        if (push_accept && push_ok) begin
            var_level[push_addr] <= push_req.level;
            var_value[push_addr] <= push_req.value;
            var_index[push_addr] <= height;
        end
    end

    // Table read
    always_comb begin
        lookup_index = STALE_INDEX;
        rec_level    = '0;
        rec_value    = 1'b0;
        if (query_ok) begin
            lookup_index = var_index[query_addr];
            rec_level    = var_level[query_addr];
            rec_value    = var_value[query_addr];
        end
    end

    // Valid only if the record is from a live level, a live slot,
    // and the slot still holds this variable (catches truncate leftovers)
    always_comb begin
        query = '0;
        if (query_ok && (rec_level <= current_level) && (lookup_index < height)
                && (lookup_entry.variable == query_var)) begin
            query.valid = 1'b1;
            query.level = rec_level;
            query.value = rec_value;
        end
    end

endmodule

// ==== testbench/tb_trail_manager.sv ====
/*
 * Testbench for the assignment trail
 *   Clock, reset, LFSR stimulus and a reference model of the trail
 *   Backtrack stream comparator process
 *   Push/read, query, backtrack, truncate, clear and full-trail tests
 */
module tb_trail_manager;

    import trail_pkg::*;

    logic          clk;
    logic          reset;
    logic          push;
    push_req_t     push_req;
    var_t          query_var;
    index_t        read_index;
    logic          backtrack_en;
    level_t        backtrack_target;
    logic          truncate_en;
    level_t        truncate_target;
    logic          clear_all;
    index_t        height;
    level_t        current_level;
    query_result_t query;
    trail_entry_t  read_entry;
    logic          backtrack_valid;
    bt_item_t      backtrack_item;
    logic          backtrack_done;

    // Reference model of the trail
    trail_entry_t m_entry [0:MAX_VARS-1];
    int           m_height;
    level_t       m_level;
    bit           active [1:MAX_VARS];
    bt_item_t     bt_expect [$];

    logic [15:0] lfsr = 16'd49;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;

    trail_manager DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11, one output bit per step
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    // Fresh ID in 1..MAX_VARS, never one that is still on the trail
    function automatic var_t draw_var();
        var_t v;
        do begin
            v = rand_bits(8) + 1;
        end while (active[v]);
        return v;
    endfunction

    // Expected external read, empty slot with NO_REASON above the top
    function automatic trail_entry_t ref_entry(input int idx);
        trail_entry_t e;
        e = '0;
        e.reason = NO_REASON;
        if (idx < m_height) begin
            e = m_entry[idx];
        end
        return e;
    endfunction

    // Newest live entry of the variable, visible if its level is live
    function automatic query_result_t predicted_query(input var_t v);
        query_result_t q;
        int i;
        q = '0;
        if (v >= 1 && v <= MAX_VARS) begin
            for (i = 0; i < m_height; i++) begin
                if (m_entry[i].variable == v && m_entry[i].level <= m_level) begin
                    q.valid = 1'b1;
                    q.level = m_entry[i].level;
                    q.value = m_entry[i].value;
                end
            end
        end
        return q;
    endfunction

    // Entries that survive a truncate to the target
    function automatic int kept_count(input level_t target);
        int i;
        int n;
        n = 0;
        for (i = 0; i < m_height; i++) begin
            if (m_entry[i].level <= target) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    // Backtrack stream, sampled mid-cycle against the queue built by the test
    always @(negedge clk) begin
        if (backtrack_valid === 1'b1) begin
            if (bt_expect.size() == 0) begin
                errors++;
                $display("Backtrack produced an item that was not expected");
            end else begin
                compare_value("backtrack_item", backtrack_item, bt_expect.pop_front());
            end
        end
    end

    // All driving tasks start and end 5 units after a rising edge
    task automatic push_one(input var_t v, input level_t lvl, input logic dec);
        push_req_t req;
        req.variable    = v;
        req.value       = rand_bits(1);
        req.level       = lvl;
        req.is_decision = dec;
        req.reason      = dec ? '0 : rand_bits(16);
        push     = 1'b1;
        push_req = req;
        @(posedge clk);
        #5;
        push = 1'b0;
        // Full trail drops the push
        if (m_height < MAX_VARS) begin
            m_entry[m_height].variable    = v;
            m_entry[m_height].value       = req.value;
            m_entry[m_height].level       = lvl;
            m_entry[m_height].is_decision = dec;
            m_entry[m_height].reason      = req.reason;
            m_height++;
            active[v] = 1'b1;
            if (dec) begin
                m_level = lvl;
            end
        end
        compare_value("height", height, m_height);
        compare_value("current_level", current_level, m_level);
    endtask

    task automatic verify_read(input int idx);
        read_index = idx;
        @(negedge clk);
        compare_value("read_entry", read_entry, ref_entry(idx));
        @(posedge clk);
        #5;
    endtask

    task automatic verify_query(input var_t v);
        query_var = v;
        @(negedge clk);
        compare_value("query", query, predicted_query(v));
        @(posedge clk);
        #5;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d mismatches", tests_run, name,
                     errors - errs_before);
        end
    endtask

    task automatic push_and_read();
        int e0;
        int lvl;
        int k;
        e0 = errors;
        compare_value("height", height, 0);
        compare_value("backtrack_valid", backtrack_valid, 0);
        compare_value("backtrack_done", backtrack_done, 0);
        // Level 0 implications, then a decision and six implications per level
        for (k = 0; k < 4; k++) begin
            push_one(draw_var(), 0, 1'b0);
        end
        for (lvl = 1; lvl <= 5; lvl++) begin
            push_one(draw_var(), lvl, 1'b1);
            for (k = 0; k < 6; k++) begin
                push_one(draw_var(), lvl, 1'b0);
            end
        end
        for (k = 0; k < m_height + 3; k++) begin
            verify_read(k);
        end
        report_test("push and read", e0);
    endtask

    task automatic query_all();
        int e0;
        int k;
        var_t unused;
        e0 = errors;
        for (k = 0; k < m_height; k++) begin
            verify_query(m_entry[k].variable);
        end
        unused = 1;
        while (active[unused] && unused < MAX_VARS) begin
            unused++;
        end
        verify_query(unused);
        verify_query(0);
        verify_query(MAX_VARS + 1);
        verify_query(32'hffff_ffff);
        report_test("query", e0);
    endtask

    task automatic backtrack_to_two();
        var_t gone [$];
        bt_item_t item;
        int e0;
        int i;
        int cycles;
        logic seen;
        e0 = errors;
        // Walk down from the top while entries sit above level 2
        i = m_height - 1;
        while (i >= 0 && m_entry[i].level > 2) begin
            item.variable    = m_entry[i].variable;
            item.value       = m_entry[i].value;
            item.is_decision = m_entry[i].is_decision;
            bt_expect.push_back(item);
            gone.push_back(m_entry[i].variable);
            i--;
        end
        backtrack_en     = 1'b1;
        backtrack_target = 2;
        @(posedge clk);
        #5;
        backtrack_en = 1'b0;
        seen = 1'b0;
        for (cycles = 0; cycles < MAX_VARS + 10 && !seen; cycles++) begin
            @(negedge clk);
            seen = backtrack_done;
        end
        if (!seen) begin
            errors++;
            $display("Timeout: backtrack_done did not arrive within %0d cycles",
                     MAX_VARS + 10);
        end
        @(posedge clk);
        #5;
        compare_value("backtrack_items_left", bt_expect.size(), 0);
        bt_expect.delete();
        m_height = i + 1;
        m_level  = 2;
        foreach (gone[k]) active[gone[k]] = 1'b0;
        compare_value("height", height, m_height);
        compare_value("current_level", current_level, m_level);
        foreach (gone[k]) verify_query(gone[k]);
        for (i = 0; i < m_height; i++) begin
            verify_query(m_entry[i].variable);
        end
        report_test("iterative backtrack", e0);
    endtask

    task automatic truncate_new_levels();
        var_t gone [$];
        int e0;
        int i;
        int lvl;
        e0 = errors;
        for (lvl = 3; lvl <= 4; lvl++) begin
            push_one(draw_var(), lvl, 1'b1);
            for (i = 0; i < 5; i++) begin
                push_one(draw_var(), lvl, 1'b0);
            end
        end
        for (i = kept_count(3); i < m_height; i++) begin
            gone.push_back(m_entry[i].variable);
        end
        truncate_en     = 1'b1;
        truncate_target = 3;
        @(posedge clk);
        #5;
        truncate_en = 1'b0;
        m_height = kept_count(3);
        m_level  = 3;
        foreach (gone[k]) active[gone[k]] = 1'b0;
        compare_value("height", height, m_height);
        compare_value("current_level", current_level, m_level);
        foreach (gone[k]) verify_query(gone[k]);
        verify_query(m_entry[m_height-1].variable);
        verify_read(m_height);
        report_test("truncate", e0);
    endtask

    task automatic clear_and_fill();
        var_t gone [$];
        int e0;
        int i;
        e0 = errors;
        for (i = 0; i < m_height; i++) begin
            gone.push_back(m_entry[i].variable);
        end
        clear_all = 1'b1;
        @(posedge clk);
        #5;
        clear_all = 1'b0;
        m_height = 0;
        m_level  = 0;
        foreach (gone[k]) active[gone[k]] = 1'b0;
        compare_value("height", height, 0);
        compare_value("current_level", current_level, 0);
        foreach (gone[k]) verify_query(gone[k]);
        // Three pushes past capacity must be dropped
        for (i = 0; i < MAX_VARS + 3; i++) begin
            push_one((i % MAX_VARS) + 1, 0, 1'b0);
        end
        verify_read(MAX_VARS - 1);
        verify_read(MAX_VARS);
        verify_query(MAX_VARS);
        report_test("clear and full trail", e0);
    endtask

    initial begin
        reset            = 1'b1;
        push             = 1'b0;
        push_req         = '0;
        query_var        = '0;
        read_index       = '0;
        backtrack_en     = 1'b0;
        backtrack_target = '0;
        truncate_en      = 1'b0;
        truncate_target  = '0;
        clear_all        = 1'b0;
        m_height         = 0;
        m_level          = '0;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;

        push_and_read();
        query_all();
        backtrack_to_two();
        truncate_new_levels();
        clear_and_fill();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
